//--- rv_ctrl_macros.svh
`ifndef RV_CTRL_MACROS_SVH
`define RV_CTRL_MACROS_SVH

// Special architectural registers.
`define RV_ZERO 5'd0 // Hard-wired zero.
`define RV_RA 5'd1 // Link register.
`define RV_SP 5'd2 // Stack pointer.

// Load/store access type for a full word, same as func3 of lw/sw.
`define RV_RW_WORD 3'b010

// Return address stack geometry.
`define RAS_DEPTH 8 // Entries.
`define RAS_PTR_W 3 // Wraps at RAS_DEPTH.

`endif

//--- rv_ctrl_pkg.sv
package rv_ctrl_pkg;

	// Architectural register number.
	typedef logic [4:0] reg_idx_t;

	// Operand source select.
	// Bit 1 takes the MEM-stage ALU result and wins over bit 0.
	// Bit 0 takes the WB-stage value, zero means register file.
	typedef logic [1:0] fwd_sel_t;

	// Load/store access type, encoded as load func3.
	typedef logic [2:0] rw_type_t;

	// Decoded, sign-extended immediate.
	typedef logic [31:0] imm_t;

	// Instruction address.
	typedef logic [31:0] addr_t;

endpackage : rv_ctrl_pkg

//--- pipe_track.sv
`timescale 1ns/1ns

module pipe_track (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_ctrl_pkg::reg_idx_t rd,
	input  logic                  reg_write,
	input  logic                  mem_read,
	input  rv_ctrl_pkg::rw_type_t rw_type,
	input  logic                  jal,
	input  logic                  jalr,
	input  logic                  pl_flush,
	input  logic                  pl_stall_ex,
	input  logic                  pl_stall_if,
	output rv_ctrl_pkg::reg_idx_t rd_id,
	output rv_ctrl_pkg::reg_idx_t rd_ex,
	output rv_ctrl_pkg::reg_idx_t rd_mem,
	output rv_ctrl_pkg::reg_idx_t rd_wb,
	output logic                  reg_write_id,
	output logic                  reg_write_ex,
	output logic                  reg_write_mem,
	output logic                  reg_write_wb,
	output logic                  mem_read_id,
	output logic                  mem_read_ex,
	output logic                  mem_read_mem,
	output rv_ctrl_pkg::rw_type_t rw_type_id,
	output rv_ctrl_pkg::rw_type_t rw_type_ex,
	output rv_ctrl_pkg::rw_type_t rw_type_mem,
	output logic                  jal_id,
	output logic                  jalr_id
);

	logic id_bubble;

	assign id_bubble = pl_flush || pl_stall_if; // ID takes no new instruction.

	// Control bits of each stage; flush kills ID and EX, stall_ex freezes them.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			reg_write_id  <= 1'b0;
			reg_write_ex  <= 1'b0;
			reg_write_mem <= 1'b0;
			reg_write_wb  <= 1'b0;
			mem_read_id   <= 1'b0;
			mem_read_ex   <= 1'b0;
			mem_read_mem  <= 1'b0;
			jal_id        <= 1'b0;
			jalr_id       <= 1'b0;
		end else begin
			reg_write_wb <= reg_write_mem;
			if (pl_stall_ex && !pl_flush) begin
				reg_write_mem <= 1'b0; // Bubble into MEM.
				mem_read_mem  <= 1'b0;
			end else begin
				reg_write_mem <= reg_write_ex;
				mem_read_mem  <= mem_read_ex;
				reg_write_ex  <= reg_write_id && !pl_flush;
				mem_read_ex   <= mem_read_id && !pl_flush;
				reg_write_id  <= reg_write && !id_bubble;
				mem_read_id   <= mem_read && !id_bubble;
				jal_id        <= jal && !id_bubble;
				jalr_id       <= jalr && !id_bubble;
			end
		end
	end

	// Payload fields follow the same movement.
	always_ff @(posedge clk) begin
		if (!pl_stall_ex) begin
			rd_id      <= rd;
			rw_type_id <= rw_type;
			rd_ex      <= rd_id;
			rw_type_ex <= rw_type_id;
		end
		rd_mem      <= rd_ex;
		rw_type_mem <= rw_type_ex;
		rd_wb       <= rd_mem;
	end

endmodule

//--- mini_control.sv
`timescale 1ns/1ns
`include "rv_ctrl_macros.svh"

module mini_control (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_ctrl_pkg::reg_idx_t rs1,
	input  rv_ctrl_pkg::reg_idx_t rs2,
	input  rv_ctrl_pkg::reg_idx_t rd,
	input  rv_ctrl_pkg::reg_idx_t rd_id,
	input  rv_ctrl_pkg::reg_idx_t rd_ex,
	input  rv_ctrl_pkg::reg_idx_t rd_mem,
	input  rv_ctrl_pkg::reg_idx_t rd_wb,
	input  logic                  reg_write_id,
	input  logic                  reg_write_ex,
	input  logic                  reg_write_mem,
	input  logic                  reg_write_wb,
	input  logic                  mem_read_id,
	input  logic                  mem_read_ex,
	input  logic                  mem_read_mem,
	input  rv_ctrl_pkg::rw_type_t rw_type_id,
	input  rv_ctrl_pkg::rw_type_t rw_type_ex,
	input  rv_ctrl_pkg::rw_type_t rw_type_mem,
	input  logic                  jal_id,
	input  logic                  jalr_id,
	input  logic [2:0]            func3,
	input  rv_ctrl_pkg::imm_t     imme,
	input  logic                  i_type,
	input  logic                  s_type,
	input  logic                  b_type,
	input  logic                  jal,
	input  logic                  jalr,
	input  logic                  pl_flush,
	input  logic                  pl_stall_ex,
	input  logic                  fwd_a_eq_pred,
	input  rv_ctrl_pkg::reg_idx_t ra_track,
	output rv_ctrl_pkg::fwd_sel_t rs1_fwd,
	output rv_ctrl_pkg::fwd_sel_t rs2_fwd,
	output logic                  b_type_prediction_en,
	output logic                  jalr_prediction_en,
	output logic                  pl_stall_if,
	output logic                  ras_push,
	output logic                  ras_pop,
	output logic                  ras_rollback_pop_id,
	output logic                  ras_rollback_push_id,
	output logic                  ras_rollback_push_ex,
	output logic                  wr_ra_track_en,
	output rv_ctrl_pkg::reg_idx_t wr_ra_track_data
);

	logic rs1_hz_id, rs1_hz_ex, rs1_hz_mem, rs1_hz_wb;
	logic rs2_hz_id, rs2_hz_ex, rs2_hz_mem, rs2_hz_wb;
	logic rs1_hz_ex_noload, rs1_hz_mem_load, rs2_hz_mem_load;
	logic rs1_lw_id, rs1_lw_ex, rs1_lw_mem;
	logic imm_zero, rs1_is_ra, rd_is_ra, rd_id_is_ra;
	logic ras_hit, pl_allow, track_mv, track_sw;
	logic pop_hist_id, pop_hist_ex;

	// Source matches against each in-flight destination.
	assign rs1_hz_id  = reg_write_id && (rd_id == rs1);
	assign rs1_hz_ex  = reg_write_ex && (rd_ex == rs1);
	assign rs1_hz_mem = reg_write_mem && (rd_mem == rs1);
	assign rs1_hz_wb  = reg_write_wb && (rd_wb == rs1);
	assign rs2_hz_id  = reg_write_id && (rd_id == rs2);
	assign rs2_hz_ex  = reg_write_ex && (rd_ex == rs2);
	assign rs2_hz_mem = reg_write_mem && (rd_mem == rs2);
	assign rs2_hz_wb  = reg_write_wb && (rd_wb == rs2);

	assign rs1_hz_ex_noload = rs1_hz_ex && !mem_read_ex;
	assign rs1_hz_mem_load  = rs1_hz_mem && mem_read_mem;
	assign rs2_hz_mem_load  = rs2_hz_mem && mem_read_mem;

	// A load in MEM has no ALU result to forward.
	assign rs1_fwd = {rs1_hz_mem && !mem_read_mem, rs1_hz_wb};
	assign rs2_fwd = {rs2_hz_mem && !mem_read_mem, rs2_hz_wb};

	assign b_type_prediction_en = b_type && (rs1_hz_id || rs2_hz_id || rs1_hz_ex ||
		rs2_hz_ex || rs1_hz_mem_load || rs2_hz_mem_load);

	// rs1 waits on an in-flight word load.
	assign rs1_lw_id  = rs1_hz_id && mem_read_id && (rw_type_id == `RV_RW_WORD);
	assign rs1_lw_ex  = rs1_hz_ex && mem_read_ex && (rw_type_ex == `RV_RW_WORD);
	assign rs1_lw_mem = rs1_hz_mem_load && (rw_type_mem == `RV_RW_WORD);

	assign imm_zero    = ~|imme[11:0];
	assign rs1_is_ra   = rs1 == `RV_RA;
	assign rd_is_ra    = rd == `RV_RA;
	assign rd_id_is_ra = rd_id == `RV_RA;

	// Canonical return, a copy of ra, or ra reloaded from the stack frame.
	assign ras_hit = ((rd == `RV_ZERO) && rs1_is_ra && imm_zero) ||
		((rs1 == ra_track) && !rs1_is_ra) ||
		((ra_track == `RV_ZERO) && (rs1_lw_id || rs1_lw_ex || rs1_lw_mem));

	assign jalr_prediction_en = jalr && ras_hit &&
		(rs1_hz_id || rs1_hz_ex || rs1_hz_mem_load);
	assign pl_stall_if = jalr && !ras_hit && !rs1_hz_id &&
		(rs1_hz_ex_noload || rs1_hz_mem_load);

	assign pl_allow = !pl_flush && !pl_stall_ex && !pl_stall_if;
	assign ras_push = pl_allow && rd_is_ra && (jal || jalr); // Call.
	assign ras_pop  = pl_allow && jalr && (jalr_prediction_en || fwd_a_eq_pred);

	// Undo what the flushed ID and EX instructions did to the stack.
	assign ras_rollback_pop_id  = pl_flush && rd_id_is_ra && (jal_id || jalr_id);
	assign ras_rollback_push_id = pl_flush && pop_hist_id;
	assign ras_rollback_push_ex = pl_flush && pop_hist_ex;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pop_hist_id <= 1'b0;
			pop_hist_ex <= 1'b0;
		end else if (!pl_stall_ex) begin
			pop_hist_id <= ras_pop; // Pop now sitting in ID.
			pop_hist_ex <= pop_hist_id;
		end
	end

	// mv rd, ra moves the link; sw ra, imm(sp) parks it in memory.
	assign track_mv = i_type && (func3 == 3'b000) && imm_zero && rs1_is_ra;
	assign track_sw = s_type && (func3 == `RV_RW_WORD) && (rs2 == `RV_RA) && (rs1 == `RV_SP);

	assign wr_ra_track_en   = track_mv || track_sw;
	assign wr_ra_track_data = track_sw ? `RV_ZERO : rd;

endmodule

//--- return_predictor.sv
`timescale 1ns/1ns
`include "rv_ctrl_macros.svh"

module return_predictor (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ras_push,
	input  logic                  ras_pop,
	input  logic                  ras_rollback_pop_id,
	input  logic                  ras_rollback_push_id,
	input  logic                  ras_rollback_push_ex,
	input  rv_ctrl_pkg::addr_t    link_addr,
	input  logic                  wr_ra_track_en,
	input  rv_ctrl_pkg::reg_idx_t wr_ra_track_data,
	output rv_ctrl_pkg::addr_t    pred_target,
	output rv_ctrl_pkg::reg_idx_t ra_track
);

	typedef logic [`RAS_PTR_W-1:0] ptr_t;

	rv_ctrl_pkg::addr_t stack [`RAS_DEPTH];
	ptr_t               ptr; // Next free slot.
	ptr_t               top_idx;
	logic               push_only, pop_only, replace_top;
	logic [1:0]         n_up;
	logic [1:0]         n_down;

	assign top_idx     = ptr - ptr_t'(1);
	assign pred_target = stack[top_idx];

	assign replace_top = ras_push && ras_pop; // Pop then push, pointer stays.
	assign push_only   = ras_push && !ras_pop;
	assign pop_only    = ras_pop && !ras_push;

	// Rollbacks only move the pointer.
	assign n_up   = 2'(push_only) + 2'(ras_rollback_push_id) + 2'(ras_rollback_push_ex);
	assign n_down = 2'(pop_only) + 2'(ras_rollback_pop_id);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr <= '0;
			for (int i = 0; i < `RAS_DEPTH; i++) begin
				stack[i] <= '0;
			end
		end else begin
			ptr <= ptr + ptr_t'(n_up) - ptr_t'(n_down); // Wraps, oldest is lost.
			if (push_only) begin
				stack[ptr] <= link_addr;
			end else if (replace_top) begin
				stack[top_idx] <= link_addr;
			end
		end
	end

	// Register that currently holds the return address.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ra_track <= `RV_RA;
		end else if (wr_ra_track_en) begin
			ra_track <= wr_ra_track_data;
		end
	end

endmodule

//--- ctrl_top.sv
`timescale 1ns/1ns

module ctrl_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_ctrl_pkg::reg_idx_t rs1,
	input  rv_ctrl_pkg::reg_idx_t rs2,
	input  rv_ctrl_pkg::reg_idx_t rd,
	input  logic [2:0]            func3,
	input  rv_ctrl_pkg::imm_t     imme,
	input  logic                  reg_write,
	input  logic                  mem_read,
	input  rv_ctrl_pkg::rw_type_t rw_type,
	input  logic                  i_type,
	input  logic                  s_type,
	input  logic                  b_type,
	input  logic                  jal,
	input  logic                  jalr,
	input  rv_ctrl_pkg::addr_t    link_addr,
	input  logic                  pl_flush,
	input  logic                  pl_stall_ex,
	input  logic                  fwd_a_eq_pred,
	output rv_ctrl_pkg::fwd_sel_t rs1_fwd,
	output rv_ctrl_pkg::fwd_sel_t rs2_fwd,
	output logic                  b_type_prediction_en,
	output logic                  jalr_prediction_en,
	output logic                  pl_stall_if,
	output rv_ctrl_pkg::addr_t    pred_target
);

	// Stage copies for hazard detection.
	rv_ctrl_pkg::reg_idx_t rd_id, rd_ex, rd_mem, rd_wb;
	rv_ctrl_pkg::rw_type_t rw_type_id, rw_type_ex, rw_type_mem;
	logic                  reg_write_id, reg_write_ex, reg_write_mem, reg_write_wb;
	logic                  mem_read_id, mem_read_ex, mem_read_mem;
	logic                  jal_id, jalr_id;

	// Return stack commands.
	logic                  ras_push, ras_pop;
	logic                  ras_rollback_pop_id, ras_rollback_push_id, ras_rollback_push_ex;
	logic                  wr_ra_track_en;
	rv_ctrl_pkg::reg_idx_t wr_ra_track_data;
	rv_ctrl_pkg::reg_idx_t ra_track;

	pipe_track u_pipe_track (.*);

	mini_control u_mini_control (.*);

	return_predictor u_return_predictor (.*);

endmodule

//--- ctrl_properties.sv
`timescale 1ns/1ns
`include "rv_ctrl_macros.svh"

module ctrl_properties (
	input logic clk,
	input logic rst_n,
	input logic ras_push,
	input logic ras_rollback_pop_id,
	input logic ras_rollback_push_id,
	input logic ras_rollback_push_ex,
	input logic pl_flush,
	input logic pl_stall_ex,
	input logic pl_stall_if,
	input logic reg_write_id,
	input logic reg_write_ex,
	input logic mem_read_id,
	input logic mem_read_ex,
	input logic jal_id,
	input logic jalr_id
);

	// Stack stays quiet while in reset.
	a_reset_quiet: assert property (@(posedge clk) !rst_n |->
		!ras_push && !ras_rollback_pop_id && !ras_rollback_push_id && !ras_rollback_push_ex)
		else $error("Return stack command active during reset.");

	// A fetch stall leaves a bubble in ID.
	a_stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		pl_stall_if && !pl_stall_ex |=> !reg_write_id && !mem_read_id && !jal_id && !jalr_id)
		else $error("Fetch stall did not leave a bubble in ID.");

	a_flush_kill: assert property (@(posedge clk) disable iff (!rst_n)
		pl_flush |=> !reg_write_id && !reg_write_ex && !mem_read_ex && !jal_id && !jalr_id)
		else $error("Flushed ID or EX stage still active."); // Both stages emptied.

endmodule

bind ctrl_top ctrl_properties u_ctrl_properties (.*);

//--- tb_ctrl.sv
`timescale 1ns/1ns

module tb_ctrl;

	localparam int MAX_CYCLES = 200;
	localparam int MAX_LINES  = 500;

	logic                  clk;
	logic                  rst_n;
	rv_ctrl_pkg::reg_idx_t rs1, rs2, rd;
	logic [2:0]            func3;
	rv_ctrl_pkg::imm_t     imme;
	logic                  reg_write, mem_read;
	rv_ctrl_pkg::rw_type_t rw_type;
	logic                  i_type, s_type, b_type, jal, jalr;
	rv_ctrl_pkg::addr_t    link_addr;
	logic                  pl_flush, pl_stall_ex, fwd_a_eq_pred;
	rv_ctrl_pkg::fwd_sel_t rs1_fwd, rs2_fwd;
	logic                  b_type_prediction_en, jalr_prediction_en, pl_stall_if;
	rv_ctrl_pkg::addr_t    pred_target;

	logic [31:0] fld [0:23]; // One parsed vector.
	int          fd;
	int          cur_test;
	int          test_errors;
	int          pass_count;
	int          fail_count;
	int          cycles;
	bit          have_vec;
	bit          broken;
	bit          timed_out;

	ctrl_top UUT (.*);

	always #50 clk = ~clk;

	task automatic drive_idle();
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		func3 = '0;
		imme = '0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		rw_type = '0;
		i_type = 1'b0;
		s_type = 1'b0;
		b_type = 1'b0;
		jal = 1'b0;
		jalr = 1'b0;
		link_addr = '0;
		pl_flush = 1'b0;
		pl_stall_ex = 1'b0;
		fwd_a_eq_pred = 1'b0;
	endtask

	task automatic apply_vector();
		rs1 = fld[1][4:0];
		rs2 = fld[2][4:0];
		rd = fld[3][4:0];
		func3 = fld[4][2:0];
		imme = fld[5];
		reg_write = fld[6][0];
		mem_read = fld[7][0];
		rw_type = fld[8][2:0];
		i_type = fld[9][0];
		s_type = fld[10][0];
		b_type = fld[11][0];
		jal = fld[12][0];
		jalr = fld[13][0];
		link_addr = fld[14];
		pl_flush = fld[15][0];
		pl_stall_ex = fld[16][0];
		fwd_a_eq_pred = fld[17][0];
	endtask

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0t ns: test %0d, %s is %0h, expected %0h",
				$time, cur_test, name, got, exp);
			test_errors++;
		end
	endtask

	// Skips comment and blank lines.
	task automatic read_vector(output bit found);
		string line;
		int    n;
		int    lines;
		found = 1'b0;
		lines = 0;
		while (!found && !$feof(fd) && lines < MAX_LINES) begin
			n = $fgets(line, fd);
			lines++;
			if (n > 0 && line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
					fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15],
					fld[16], fld[17], fld[18], fld[19], fld[20], fld[21], fld[22], fld[23]);
				if (n == 24) begin
					found = 1'b1;
				end else begin
					$display("Stimulus line could not be parsed: %s", line);
					broken = 1'b1;
				end
			end
		end
		if (!found && lines >= MAX_LINES) begin
			$display("Gave up reading the stimulus file after %0d lines", lines);
			broken = 1'b1;
		end
	endtask

	task automatic close_test();
		if (test_errors == 0) begin
			pass_count++;
			$display("Test %0d passed", cur_test);
		end else begin
			fail_count++;
			$display("Test %0d failed with %0d errors", cur_test, test_errors);
		end
		test_errors = 0;
	endtask

	// One clock cycle: drive the vector, check just before the next edge.
	task automatic run_cycle();
		#5;
		rst_n = 1'b1;
		if (int'(fld[0]) != cur_test) begin
			if (cur_test >= 0) close_test();
			cur_test = int'(fld[0]);
		end
		apply_vector();
		#85; // Just before the next edge.
		check_field("rs1_fwd", 32'(rs1_fwd), fld[18]);
		check_field("rs2_fwd", 32'(rs2_fwd), fld[19]);
		check_field("b_type_prediction_en", 32'(b_type_prediction_en), fld[20]);
		check_field("jalr_prediction_en", 32'(jalr_prediction_en), fld[21]);
		check_field("pl_stall_if", 32'(pl_stall_if), fld[22]);
		check_field("pred_target", pred_target, fld[23]);
		cycles++;
		@(posedge clk);
	endtask

	// Branch hazard vector, all other inputs idle.
	task automatic set_branch_vector(input int s1, input int s2, input int dst,
		input bit wr, input bit ld, input bit br, input int exp_fwd1,
		input int exp_fwd2, input bit exp_pred);
		foreach (fld[i]) begin
			fld[i] = '0;
		end
		fld[0] = 32'd7;
		fld[1] = 32'(s1);
		fld[2] = 32'(s2);
		fld[3] = 32'(dst);
		fld[4] = ld ? 32'd2 : 32'd0; // Word access.
		fld[6] = 32'(wr);
		fld[7] = 32'(ld);
		fld[8] = ld ? 32'd2 : 32'd0;
		fld[11] = 32'(br);
		fld[18] = 32'(exp_fwd1);
		fld[19] = 32'(exp_fwd2);
		fld[20] = 32'(exp_pred);
	endtask

	// A branch is predicted on an ID or EX match, or on a load in MEM.
	task automatic run_branch_checks();
		set_branch_vector(0, 0, 0, 0, 0, 0, 0, 0, 0);
		run_cycle();
		set_branch_vector(0, 0, 10, 1, 0, 0, 0, 0, 0); // ALU write to x10.
		run_cycle();
		set_branch_vector(10, 0, 0, 0, 0, 1, 0, 0, 1); // x10 in ID.
		run_cycle();
		set_branch_vector(0, 10, 0, 0, 0, 1, 0, 0, 1); // x10 in EX.
		run_cycle();
		set_branch_vector(10, 0, 0, 0, 0, 1, 2, 0, 0); // Forwarded from MEM.
		run_cycle();
		set_branch_vector(0, 0, 11, 1, 1, 0, 0, 0, 0); // lw x11.
		run_cycle();
		set_branch_vector(0, 0, 0, 0, 0, 0, 0, 0, 0);
		run_cycle();
		run_cycle();
		set_branch_vector(0, 11, 0, 0, 0, 1, 0, 0, 1); // Load in MEM.
		run_cycle();
		set_branch_vector(11, 0, 0, 0, 0, 1, 1, 0, 0); // Load in WB.
		run_cycle();
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		drive_idle();
		cur_test = -1;
		test_errors = 0;
		pass_count = 0;
		fail_count = 0;
		cycles = 0;
		broken = 1'b0;
		timed_out = 1'b0;
		have_vec = 1'b0;
		fd = $fopen("ctrl_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file ctrl_stim.txt");
			broken = 1'b1;
		end else begin
			repeat (10) @(posedge clk);
			read_vector(have_vec);
			if (!have_vec) begin
				$display("The stimulus file holds no vectors");
				broken = 1'b1;
			end
			while (have_vec && cycles < MAX_CYCLES) begin
				run_cycle();
				read_vector(have_vec);
			end
			if (have_vec) begin
				$display("Timed out after %0d cycles with vectors still unread", cycles);
				timed_out = 1'b1;
			end
			$fclose(fd);
			run_branch_checks();
			if (cur_test >= 0) close_test();
		end
		$display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && !broken && !timed_out) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+.
rv_ctrl_pkg.sv
pipe_track.sv
mini_control.sv
return_predictor.sv
ctrl_top.sv
ctrl_properties.sv
tb_ctrl.sv

//--- Makefile
# Verilator build and run for the decode-stage control subsystem.

VERILATOR ?= verilator
TOP       ?= tb_ctrl
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell sed -e '/^+/d' $(FILELIST)) $(FILELIST) rv_ctrl_macros.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ctrl_stim.txt
# test rs1 rs2 rd func3 imme reg_write mem_read rw_type i_type s_type b_type jal jalr link_addr
#   pl_flush pl_stall_ex fwd_a_eq_pred | exp: rs1_fwd rs2_fwd b_pred jalr_pred stall_if pred_target
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 5 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 6 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 5 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0
2 6 5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 1 0 0 0 0
2 0 0 8 2 0 1 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 8 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 8 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0
2 0 0 9 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 9 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 9 9 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 3 0 0 0 0
3 0 0 1 0 0 1 0 0 0 0 0 1 0 100 0 0 0 0 0 0 0 0 0
3 0 0 1 0 0 1 0 0 0 0 0 1 0 200 0 0 0 0 0 0 0 0 100
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 200
3 1 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 2 0 0 1 0 200
3 0 0 1 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 100
3 1 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 1 0 0 1 0 100
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 0 0 5 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 5 0 6 0 0 1 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 1 0
4 5 0 6 0 0 1 0 0 0 0 0 0 1 0 0 0 0 2 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
4 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0
5 0 0 1 0 0 1 0 0 0 0 0 1 0 300 0 0 0 0 0 0 0 0 0
5 1 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 1 0 300
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 300
6 0 0 1 0 0 1 0 0 0 0 0 1 0 400 0 0 0 0 0 0 0 0 300
6 1 0 5 0 0 1 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 400
6 5 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 1 0 400
6 2 1 0 2 0 0 0 0 0 1 0 0 0 0 0 0 0 0 2 0 0 0 300
6 0 0 7 2 0 1 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 300
6 7 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 1 0 300
6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
